//--- src/cpuPkg.sv
package cpuPkg;

	typedef logic [15:0] wordT; // data, address and instruction word
	typedef logic [1:0] regSelT; // 0 ax, 1 bx, 2 cx, 3 dx

	localparam int memDepthLog2 = 11; // 2048 words of program and data
	localparam int stackDepthLog2 = 10; // 1024 stack words

	typedef enum logic [15:0] {
		opNop  = 16'h0000,
		opScf  = 16'h0001,
		opCff  = 16'h0002,
		opCof  = 16'h0003,
		opCzf  = 16'h0004,
		opMov1 = 16'h0005, // [p1+bp] <= reg p2
		opMov2 = 16'h0006, // reg p1 <= [p2+bp]
		opMov3 = 16'h0007, // reg to reg
		opMov4 = 16'h0008, // immediate
		opPop  = 16'h0009,
		opOut  = 16'h000A,
		opPush = 16'h000B,
		opAdd  = 16'h000C,
		opAdc  = 16'h000D,
		opSub  = 16'h000E,
		opSuc  = 16'h000F,
		opCmp  = 16'h0014,
		opAnd  = 16'h0015,
		opNeg  = 16'h0016,
		opNot  = 16'h0017,
		opOr   = 16'h0018,
		opShl  = 16'h0019,
		opShr  = 16'h001A,
		opXor  = 16'h001B,
		opTest = 16'h001C,
		opCall = 16'h001E,
		opRet  = 16'h001F,
		opJmp  = 16'h0020,
		opJc   = 16'h0021,
		opJnc  = 16'h0022,
		opJz   = 16'h0023,
		opJnz  = 16'h0024,
		opJo   = 16'h0025,
		opJno  = 16'h0026,
		opXch  = 16'h0029,
		opMov5 = 16'h002A, // absolute store
		opMov6 = 16'h002B  // absolute load
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd, aluAdc, aluSub, aluSuc, aluCmp,
		aluAnd, aluOr, aluXor, aluNot, aluNeg,
		aluShl, aluShr, aluTest
	} aluOpT;

	// words per instruction, indexed by opcode[5:0]
	localparam logic [1:0] instrLen [64] = '{
		opScf: 2'd2, opMov1: 2'd3, opMov2: 2'd3, opMov3: 2'd2, opMov4: 2'd3,
		opPop: 2'd2, opPush: 2'd2, opAnd: 2'd2, opNeg: 2'd2, opNot: 2'd2,
		opOr: 2'd2, opShl: 2'd2, opShr: 2'd2, opXor: 2'd2, opTest: 2'd2,
		opCall: 2'd2, opJmp: 2'd2, opJc: 2'd2, opJnc: 2'd2, opJz: 2'd2,
		opJnz: 2'd2, opJo: 2'd2, opJno: 2'd2, opXch: 2'd2, opMov5: 2'd3,
		opMov6: 2'd3,
		default: 2'd1
	};

endpackage

//--- src/progMemory.sv
`timescale 1ns/1ns
module progMemory #(
	parameter int memAddrBits = cpuPkg::memDepthLog2
) (
	input  logic         clk,
	input  logic         loadEn,
	input  cpuPkg::wordT loadAddr,
	input  cpuPkg::wordT loadData,
	input  cpuPkg::wordT fetchAddr,
	output cpuPkg::wordT fetchOp,
	output cpuPkg::wordT fetchP1,
	output cpuPkg::wordT fetchP2,
	input  cpuPkg::wordT dataAddr,
	input  logic         dataWe,
	input  cpuPkg::wordT dataWd,
	output cpuPkg::wordT dataRd
);
	cpuPkg::wordT mem [2**memAddrBits];
	cpuPkg::wordT addrP1;
	cpuPkg::wordT addrP2;

	assign addrP1 = fetchAddr + 16'd1;
	assign addrP2 = fetchAddr + 16'd2;

	// opcode plus both parameter words in one cycle
	assign fetchOp = mem[fetchAddr[memAddrBits-1:0]];
	assign fetchP1 = mem[addrP1[memAddrBits-1:0]];
	assign fetchP2 = mem[addrP2[memAddrBits-1:0]];
	assign dataRd = mem[dataAddr[memAddrBits-1:0]];

	always_ff @(posedge clk) begin
		if (loadEn) begin
			mem[loadAddr[memAddrBits-1:0]] <= loadData; // load port wins
		end else if (dataWe) begin
			mem[dataAddr[memAddrBits-1:0]] <= dataWd;
		end
	end

endmodule

//--- src/callStack.sv
`timescale 1ns/1ns
module callStack #(
	parameter int stackAddrBits = cpuPkg::stackDepthLog2
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         push,
	input  logic         pop,
	input  logic         pair,
	input  cpuPkg::wordT pushLo,
	input  cpuPkg::wordT pushHi,
	output cpuPkg::wordT top,
	output cpuPkg::wordT below
);
	cpuPkg::wordT stack [2**stackAddrBits];
	logic [stackAddrBits-1:0] sp; // next free slot
	logic [stackAddrBits-1:0] spUp1;
	logic [stackAddrBits-1:0] spDn1;
	logic [stackAddrBits-1:0] spDn2;

	assign spUp1 = sp + 1'b1;
	assign spDn1 = sp - 1'b1;
	assign spDn2 = sp - 2'd2;

	assign top = stack[spDn1];
	assign below = stack[spDn2];

	always_ff @(posedge clk) begin
		if (push) begin
			stack[sp] <= pushLo;
			if (pair) stack[spUp1] <= pushHi; // hi lands on top
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			sp <= '0;
		end else if (push) begin
			sp <= pair ? sp + 2'd2 : spUp1;
		end else if (pop) begin
			sp <= pair ? spDn2 : spDn1;
		end
	end

endmodule

//--- src/regFile.sv
`timescale 1ns/1ns
module regFile (
	input  logic           clk,
	input  logic           reset,
	input  cpuPkg::regSelT rdSelA,
	input  cpuPkg::regSelT rdSelB,
	output cpuPkg::wordT   rdA,
	output cpuPkg::wordT   rdB,
	input  logic           we1,
	input  cpuPkg::regSelT wrSel1,
	input  cpuPkg::wordT   wrData1,
	input  logic           we2,
	input  cpuPkg::regSelT wrSel2,
	input  cpuPkg::wordT   wrData2,
	output cpuPkg::wordT   dxOut,
	output cpuPkg::wordT   bxOut
);
	cpuPkg::wordT regs [4]; // ax bx cx dx

	assign rdA = regs[rdSelA];
	assign rdB = regs[rdSelB];
	assign bxOut = regs[1];
	assign dxOut = regs[3];

	// second port only used by XCH so both halves of the swap land together
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (we1) regs[wrSel1] <= wrData1;
			if (we2) regs[wrSel2] <= wrData2;
		end
	end

endmodule

//--- src/alu.sv
`timescale 1ns/1ns
module alu (
	input  logic          clk,
	input  logic          reset,
	input  logic          start,
	input  cpuPkg::aluOpT op,
	input  cpuPkg::wordT  a,
	input  cpuPkg::wordT  b,
	input  logic          carryIn,
	output cpuPkg::wordT  result,
	output logic          cFlag,
	output logic          zFlag,
	output logic          oFlag
);
	logic [16:0] wide; // bit 16 is carry or borrow
	logic ovf;
	logic cin;

	assign cin = carryIn & ((op == cpuPkg::aluAdc) | (op == cpuPkg::aluSuc));

	always_comb begin
		ovf = 1'b0;
		case (op)
			cpuPkg::aluAdd, cpuPkg::aluAdc: begin
				wide = {1'b0, a} + {1'b0, b} + {16'd0, cin};
				ovf = (a[15] == b[15]) && (wide[15] != a[15]);
			end
			cpuPkg::aluSub, cpuPkg::aluSuc, cpuPkg::aluCmp: begin
				wide = {1'b0, a} - {1'b0, b} - {16'd0, cin};
				ovf = (a[15] != b[15]) && (wide[15] != a[15]);
			end
			cpuPkg::aluAnd, cpuPkg::aluTest: wide = {1'b0, a & b};
			cpuPkg::aluOr: wide = {1'b0, a | b};
			cpuPkg::aluXor: wide = {1'b0, a ^ b};
			cpuPkg::aluNot: wide = {1'b0, ~a};
			cpuPkg::aluNeg: wide = 17'd0 - {1'b0, a}; // two's complement
			cpuPkg::aluShl: wide = {a, 1'b0}; // msb falls into carry
			cpuPkg::aluShr: wide = {a[0], 1'b0, a[15:1]};
			default: wide = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			result <= '0;
			cFlag <= 1'b0;
			zFlag <= 1'b0;
			oFlag <= 1'b0;
		end else if (start) begin
			result <= wide[15:0];
			cFlag <= wide[16];
			zFlag <= (wide[15:0] == 16'd0);
			oFlag <= ovf;
		end
	end

endmodule

//--- src/cpuControl.sv
`timescale 1ns/1ns
module cpuControl (
	input  logic           clk,
	input  logic           reset,
	output cpuPkg::wordT   fetchAddr,
	input  cpuPkg::wordT   fetchOp,
	input  cpuPkg::wordT   fetchP1,
	input  cpuPkg::wordT   fetchP2,
	output cpuPkg::wordT   dataAddr,
	output logic           dataWe,
	output cpuPkg::wordT   dataWd,
	input  cpuPkg::wordT   dataRd,
	output logic           push,
	output logic           pop,
	output logic           pair,
	output cpuPkg::wordT   pushLo,
	output cpuPkg::wordT   pushHi,
	input  cpuPkg::wordT   top,
	input  cpuPkg::wordT   below,
	output cpuPkg::regSelT rdSelA,
	output cpuPkg::regSelT rdSelB,
	input  cpuPkg::wordT   rdA,
	input  cpuPkg::wordT   rdB,
	output logic           we1,
	output cpuPkg::regSelT wrSel1,
	output cpuPkg::wordT   wrData1,
	output logic           we2,
	output cpuPkg::regSelT wrSel2,
	output cpuPkg::wordT   wrData2,
	input  cpuPkg::wordT   dxOut,
	input  cpuPkg::wordT   bxOut,
	output logic           aluStart,
	output cpuPkg::aluOpT  aluOp,
	output cpuPkg::wordT   aluA,
	output cpuPkg::wordT   aluB,
	output logic           aluCarryIn,
	input  cpuPkg::wordT   aluResult,
	input  logic           aluC,
	input  logic           aluZ,
	input  logic           aluO,
	output logic           outValid,
	output cpuPkg::wordT   outAddr,
	output cpuPkg::wordT   outData
);
	cpuPkg::wordT pc;
	cpuPkg::wordT bp;
	cpuPkg::wordT pcNext;
	cpuPkg::wordT bpNext;
	cpuPkg::wordT target; // jump and call destination
	logic cf, zf, of;
	logic cfNext, zfNext, ofNext;
	logic aluPhase; // high while waiting on the alu result
	logic arith, binLogic, unary;
	logic outNext;
	logic [1:0] len;

	assign fetchAddr = pc;
	assign target = fetchP1 + bp;
	assign aluCarryIn = cf;
	assign aluStart = (arith | binLogic | unary) & ~aluPhase;
	assign len = (fetchOp[15:6] == 10'd0) ? cpuPkg::instrLen[fetchOp[5:0]] : 2'd1;

	always_comb begin
		pcNext = pc + {14'd0, len};
		bpNext = bp;
		cfNext = cf;
		zfNext = zf;
		ofNext = of;
		outNext = 1'b0;
		arith = 1'b0;
		binLogic = 1'b0;
		unary = 1'b0;
		dataAddr = fetchP1;
		dataWe = 1'b0;
		dataWd = rdB;
		push = 1'b0;
		pop = 1'b0;
		pair = 1'b0;
		pushLo = rdB;
		pushHi = pc + 16'd2; // return address for CALL
		rdSelA = fetchP1[3:2];
		rdSelB = fetchP1[1:0];
		we1 = 1'b0;
		wrSel1 = fetchP1[1:0];
		wrData1 = fetchP2;
		we2 = 1'b0;
		wrSel2 = fetchP1[1:0];
		wrData2 = rdA;
		aluOp = cpuPkg::aluAdd;
		aluA = rdA;
		aluB = rdB;
		case (fetchOp)
			cpuPkg::opScf: cfNext = fetchP1[0];
			cpuPkg::opCff: begin
				we1 = 1'b1;
				wrSel1 = 2'd3;
				wrData1 = {15'd0, cf};
			end
			cpuPkg::opCof: begin
				we1 = 1'b1;
				wrSel1 = 2'd3;
				wrData1 = {15'd0, of};
			end
			cpuPkg::opCzf: begin
				we1 = 1'b1;
				wrSel1 = 2'd3;
				wrData1 = {15'd0, zf};
			end
			cpuPkg::opMov4: we1 = 1'b1; // p2 into reg p1
			cpuPkg::opMov3: begin
				we1 = 1'b1;
				wrSel1 = fetchP1[3:2];
				wrData1 = rdB;
			end
			cpuPkg::opXch: begin
				we1 = 1'b1;
				wrSel1 = fetchP1[3:2];
				wrData1 = rdB;
				we2 = 1'b1;
			end
			cpuPkg::opMov5, cpuPkg::opMov1: begin
				rdSelB = fetchP2[1:0];
				dataWe = 1'b1;
				if (fetchOp == cpuPkg::opMov1) dataAddr = target;
			end
			cpuPkg::opMov6, cpuPkg::opMov2: begin
				dataAddr = (fetchOp == cpuPkg::opMov2) ? fetchP2 + bp : fetchP2;
				we1 = 1'b1;
				wrData1 = dataRd;
			end
			cpuPkg::opPush: push = 1'b1;
			cpuPkg::opPop: begin
				pop = 1'b1;
				we1 = 1'b1;
				wrData1 = top;
			end
			cpuPkg::opOut: outNext = 1'b1;
			cpuPkg::opAdd: begin aluOp = cpuPkg::aluAdd; arith = 1'b1; end
			cpuPkg::opAdc: begin aluOp = cpuPkg::aluAdc; arith = 1'b1; end
			cpuPkg::opSub: begin aluOp = cpuPkg::aluSub; arith = 1'b1; end
			cpuPkg::opSuc: begin aluOp = cpuPkg::aluSuc; arith = 1'b1; end
			cpuPkg::opCmp: begin aluOp = cpuPkg::aluCmp; arith = 1'b1; end
			cpuPkg::opAnd: begin aluOp = cpuPkg::aluAnd; binLogic = 1'b1; end
			cpuPkg::opOr: begin aluOp = cpuPkg::aluOr; binLogic = 1'b1; end
			cpuPkg::opXor: begin aluOp = cpuPkg::aluXor; binLogic = 1'b1; end
			cpuPkg::opTest: begin aluOp = cpuPkg::aluTest; binLogic = 1'b1; end
			cpuPkg::opNot: begin aluOp = cpuPkg::aluNot; unary = 1'b1; end
			cpuPkg::opNeg: begin aluOp = cpuPkg::aluNeg; unary = 1'b1; end
			cpuPkg::opShl: begin aluOp = cpuPkg::aluShl; unary = 1'b1; end
			cpuPkg::opShr: begin aluOp = cpuPkg::aluShr; unary = 1'b1; end
			cpuPkg::opJmp: pcNext = target;
			cpuPkg::opJc: if (cf) pcNext = target;
			cpuPkg::opJnc: if (!cf) pcNext = target;
			cpuPkg::opJz: if (zf) pcNext = target;
			cpuPkg::opJnz: if (!zf) pcNext = target;
			cpuPkg::opJo: if (of) pcNext = target;
			cpuPkg::opJno: if (!of) pcNext = target;
			cpuPkg::opCall: begin
				push = 1'b1;
				pair = 1'b1;
				pushLo = bp;
				pcNext = target;
				bpNext = fetchP1;
			end
			cpuPkg::opRet: begin
				pop = 1'b1;
				pair = 1'b1;
				pcNext = top;
				bpNext = below;
			end
			default: ; // NOP and unknown opcodes
		endcase

		// fixed operands dx op ax
		if (arith) begin
			rdSelB = 2'd0;
			aluA = dxOut;
		end
		if (unary) aluA = rdB;

		if (aluPhase) begin
			wrData1 = aluResult;
			if (arith) begin
				we1 = (fetchOp != cpuPkg::opCmp);
				wrSel1 = 2'd0;
				cfNext = aluC;
				zfNext = aluZ;
				ofNext = aluO;
			end
			if (binLogic) begin
				we1 = (fetchOp != cpuPkg::opTest);
				wrSel1 = fetchP1[3:2];
				if (fetchOp == cpuPkg::opTest) zfNext = aluZ;
			end
			if (unary) we1 = 1'b1;
		end else if (arith | binLogic | unary) begin
			pcNext = pc; // issue cycle, same word decoded again next edge
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			pc <= '0;
			bp <= '0;
			cf <= 1'b0;
			zf <= 1'b0;
			of <= 1'b0;
			aluPhase <= 1'b0;
			outValid <= 1'b0;
		end else begin
			pc <= pcNext;
			bp <= bpNext;
			cf <= cfNext;
			zf <= zfNext;
			of <= ofNext;
			aluPhase <= aluStart;
			outValid <= outNext;
		end
	end

	always_ff @(posedge clk) begin
		if (outNext) begin
			outAddr <= bxOut;
			outData <= dxOut;
		end
	end

endmodule

//--- src/cpuTop.sv
`timescale 1ns/1ns
module cpuTop #(
	parameter int memAddrBits = cpuPkg::memDepthLog2,
	parameter int stackAddrBits = cpuPkg::stackDepthLog2
) (
	input  logic         clk,
	input  logic         reset,
	input  logic         loadEn,
	input  cpuPkg::wordT loadAddr,
	input  cpuPkg::wordT loadData,
	output logic         outValid,
	output cpuPkg::wordT outAddr,
	output cpuPkg::wordT outData
);
	cpuPkg::wordT fetchAddr, fetchOp, fetchP1, fetchP2;
	cpuPkg::wordT dataAddr, dataWd, dataRd;
	logic dataWe;
	logic push, pop, pair;
	cpuPkg::wordT pushLo, pushHi, top, below;
	cpuPkg::regSelT rdSelA, rdSelB, wrSel1, wrSel2;
	cpuPkg::wordT rdA, rdB, wrData1, wrData2, dxOut, bxOut;
	logic we1, we2;
	logic aluStart, aluCarryIn, aluC, aluZ, aluO;
	cpuPkg::aluOpT aluOp;
	cpuPkg::wordT aluA, aluB, aluResult;

	progMemory #(.memAddrBits(memAddrBits)) mem_i (
		.clk, .loadEn, .loadAddr, .loadData,
		.fetchAddr, .fetchOp, .fetchP1, .fetchP2,
		.dataAddr, .dataWe, .dataWd, .dataRd
	);

	callStack #(.stackAddrBits(stackAddrBits)) stack_i (
		.clk, .reset, .push, .pop, .pair, .pushLo, .pushHi, .top, .below
	);

	regFile regs_i (
		.clk, .reset, .rdSelA, .rdSelB, .rdA, .rdB,
		.we1, .wrSel1, .wrData1, .we2, .wrSel2, .wrData2, .dxOut, .bxOut
	);

	alu alu_i (
		.clk, .reset, .start(aluStart), .op(aluOp), .a(aluA), .b(aluB),
		.carryIn(aluCarryIn), .result(aluResult),
		.cFlag(aluC), .zFlag(aluZ), .oFlag(aluO)
	);

	cpuControl ctrl_i (
		.clk, .reset,
		.fetchAddr, .fetchOp, .fetchP1, .fetchP2,
		.dataAddr, .dataWe, .dataWd, .dataRd,
		.push, .pop, .pair, .pushLo, .pushHi, .top, .below,
		.rdSelA, .rdSelB, .rdA, .rdB,
		.we1, .wrSel1, .wrData1, .we2, .wrSel2, .wrData2, .dxOut, .bxOut,
		.aluStart, .aluOp, .aluA, .aluB, .aluCarryIn, .aluResult, .aluC, .aluZ, .aluO,
		.outValid, .outAddr, .outData
	);

endmodule

//--- dv/cpuTbTasks.svh
`ifndef CPU_TB_TASKS_SVH
`define CPU_TB_TASKS_SVH

logic [31:0] lfsrState; // fibonacci, taps 32 22 2 1
cpuPkg::wordT asmPc; // next free program word
cpuPkg::wordT progAddrs [$];
cpuPkg::wordT progWords [$];
cpuPkg::wordT expAddr [$]; // expected OUT pairs in order
cpuPkg::wordT expData [$];

function automatic logic nextRandBit();
	logic fb;
	fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
	lfsrState = {lfsrState[30:0], fb};
	return fb;
endfunction

function automatic cpuPkg::wordT randWord();
	cpuPkg::wordT w;
	for (int i = 0; i < 16; i++) begin
		w[i] = nextRandBit();
	end
	return w;
endfunction

// p1 operand: dst in [3:2], src in [1:0]
function automatic cpuPkg::wordT selPair(input cpuPkg::regSelT dst, input cpuPkg::regSelT src);
	return {12'd0, dst, src};
endfunction

task automatic newProgram();
	progAddrs.delete();
	progWords.delete();
	asmPc = 16'd0;
endtask

task automatic emitWord(input cpuPkg::wordT w);
	progAddrs.push_back(asmPc);
	progWords.push_back(w);
	asmPc = asmPc + 16'd1;
endtask

task automatic emitInstr(input cpuPkg::opcodeT op, input cpuPkg::wordT p1 = 16'd0,
		input cpuPkg::wordT p2 = 16'd0);
	logic [1:0] len;
	len = cpuPkg::instrLen[op[5:0]]; // words taken by this opcode
	emitWord(op);
	if (len > 2'd1) emitWord(p1);
	if (len > 2'd2) emitWord(p2);
endtask

task automatic expectOut(input cpuPkg::wordT addr, input cpuPkg::wordT data);
	expAddr.push_back(addr);
	expData.push_back(data);
endtask

// copy a register to dx and emit it, bx already holds tag
task automatic showReg(input cpuPkg::regSelT src, input cpuPkg::wordT tag,
		input cpuPkg::wordT value);
	emitInstr(cpuPkg::opMov3, selPair(regDx, src));
	emitInstr(cpuPkg::opOut);
	expectOut(tag, value);
endtask

task automatic showFlag(input cpuPkg::opcodeT copyOp, input cpuPkg::wordT tag, input logic flag);
	emitInstr(copyOp);
	emitInstr(cpuPkg::opOut);
	expectOut(tag, {15'd0, flag});
endtask

// jump over one OUT; a fall through emits bx=tag, dx=~tag first
task automatic jumpCase(input cpuPkg::opcodeT op, input logic taken, input cpuPkg::wordT tag);
	emitInstr(cpuPkg::opMov4, regBx, tag);
	emitInstr(cpuPkg::opMov4, regDx, ~tag);
	emitInstr(op, asmPc + 16'd3); // jump is 2 words, OUT is 1
	emitInstr(cpuPkg::opOut);
	emitInstr(cpuPkg::opMov4, regDx, tag);
	emitInstr(cpuPkg::opOut);
	if (!taken) expectOut(tag, ~tag);
	expectOut(tag, tag);
endtask

// one word per falling edge, core held in reset
task automatic loadProgram();
	for (int i = 0; i < progWords.size(); i++) begin
		@(negedge clk);
		loadEn = 1'b1;
		loadAddr = progAddrs[i];
		loadData = progWords[i];
	end
	@(negedge clk);
	loadEn = 1'b0;
endtask

`endif

//--- dv/cpuTb.sv
`timescale 1ns/1ns
module cpuTb;

	localparam cpuPkg::regSelT regAx = 2'd0;
	localparam cpuPkg::regSelT regBx = 2'd1;
	localparam cpuPkg::regSelT regCx = 2'd2;
	localparam cpuPkg::regSelT regDx = 2'd3;

	logic clk;
	logic reset;
	logic loadEn;
	cpuPkg::wordT loadAddr;
	cpuPkg::wordT loadData;
	logic outValid;
	cpuPkg::wordT outAddr;
	cpuPkg::wordT outData;
	cpuPkg::wordT headAddr;
	cpuPkg::wordT headData;
	int eventCount;
	int valueErrors;
	int otherErrors;

	`include "cpuTbTasks.svh"

	cpuTop #(
		.memAddrBits(cpuPkg::memDepthLog2),
		.stackAddrBits(cpuPkg::stackDepthLog2)
	) dut_i (
		.clk, .reset, .loadEn, .loadAddr, .loadData, .outValid, .outAddr, .outData
	);

	always #20 clk = ~clk;

	// each OUT event against the head of the queue
	always @(negedge clk) begin
		if (outValid === 1'b1) begin
			eventCount++;
			stray: assert (expAddr.size() > 0) else begin
				otherErrors++;
				$display("OUT event at %0t (addr %h, data %h) was not expected by any program",
					$time, outAddr, outData);
			end
			if (expAddr.size() > 0) begin
				headAddr = expAddr.pop_front();
				headData = expData.pop_front();
				outMatch: assert (outAddr === headAddr && outData === headData) else begin
					valueErrors++;
					$display("** Error at %0t: OUT gave addr %h data %h, expected addr %h data %h",
						$time, outAddr, outData, headAddr, headData);
				end
			end
		end
	end

	// signed and unsigned reference for dx op ax
	function automatic void arithModel(input cpuPkg::opcodeT op, input cpuPkg::wordT d,
			input cpuPkg::wordT a, input logic cin, output cpuPkg::wordT res,
			output logic c, output logic z, output logic o);
		int ur;
		int sr;
		int ci;
		ci = (cin && (op == cpuPkg::opAdc || op == cpuPkg::opSuc)) ? 1 : 0;
		if (op == cpuPkg::opAdd || op == cpuPkg::opAdc) begin
			ur = int'(d) + int'(a) + ci;
			sr = int'($signed(d)) + int'($signed(a)) + ci;
			c = (ur > 65535); // carry out
		end else begin
			ur = int'(d) - int'(a) - ci;
			sr = int'($signed(d)) - int'($signed(a)) - ci;
			c = (ur < 0); // borrow
		end
		res = ur[15:0];
		z = (res == 16'd0);
		o = (sr > 32767) || (sr < -32768);
	endfunction

	task automatic runProgram(input string name);
		int cycles;
		emitInstr(cpuPkg::opJmp, asmPc); // park on itself
		@(negedge clk);
		reset = 1'b0;
		loadProgram();
		repeat (10) @(negedge clk);
		reset = 1'b1;
		cycles = 0;
		while (expAddr.size() > 0 && cycles < 4000) begin
			@(negedge clk);
			cycles++;
		end
		if (expAddr.size() > 0) begin
			otherErrors++;
			$display("%s program ran short, %0d expected OUT events never came",
				name, expAddr.size());
			expAddr.delete();
			expData.delete();
		end
		repeat (20) @(negedge clk); // window for stray events
	endtask

	task automatic registerMoves();
		cpuPkg::wordT r0, r1, r2, r3;
		newProgram();
		for (int k = 0; k < 4; k++) begin
			r0 = randWord();
			r1 = randWord();
			r2 = randWord();
			r3 = randWord();
			emitInstr(cpuPkg::opMov4, regBx, r0);
			emitInstr(cpuPkg::opMov4, regDx, r1);
			emitInstr(cpuPkg::opOut);
			expectOut(r0, r1);
			emitInstr(cpuPkg::opMov4, regAx, r2);
			emitInstr(cpuPkg::opMov3, selPair(regDx, regAx));
			emitInstr(cpuPkg::opOut);
			expectOut(r0, r2);
			emitInstr(cpuPkg::opMov4, regCx, r3);
			emitInstr(cpuPkg::opXch, selPair(regBx, regCx));
			emitInstr(cpuPkg::opOut);
			expectOut(r3, r2); // cx now holds r0
			emitInstr(cpuPkg::opXch, selPair(regDx, regCx));
			emitInstr(cpuPkg::opOut);
			expectOut(r3, r0);
			emitInstr(cpuPkg::opMov3, selPair(regBx, regDx));
			emitInstr(cpuPkg::opOut);
			expectOut(r0, r0);
		end
		runProgram("register move");
	endtask

	task automatic arithmeticOps();
		cpuPkg::opcodeT ops [5];
		cpuPkg::wordT d, a, res, tag;
		logic cin, c, z, o;
		ops = '{cpuPkg::opAdd, cpuPkg::opAdc, cpuPkg::opSub, cpuPkg::opSuc, cpuPkg::opCmp};
		newProgram();
		for (int i = 0; i < 5; i++) begin
			for (int k = 0; k < 4; k++) begin
				d = randWord();
				a = randWord();
				if (k == 3) a = d; // equal operands
				cin = nextRandBit();
				tag = 16'h2000 + 16'(i * 16 + k);
				arithModel(ops[i], d, a, cin, res, c, z, o);
				emitInstr(cpuPkg::opMov4, regDx, d);
				emitInstr(cpuPkg::opMov4, regAx, a);
				emitInstr(cpuPkg::opScf, {15'd0, cin});
				emitInstr(ops[i]);
				emitInstr(cpuPkg::opMov4, regBx, tag);
				showReg(regAx, tag, (ops[i] == cpuPkg::opCmp) ? a : res);
				showFlag(cpuPkg::opCff, tag, c);
				showFlag(cpuPkg::opCzf, tag, z);
				showFlag(cpuPkg::opCof, tag, o);
			end
		end
		runProgram("arithmetic");
	endtask

	task automatic logicCase(input cpuPkg::opcodeT op, input cpuPkg::wordT x,
			input cpuPkg::wordT y, input cpuPkg::wordT tag, input cpuPkg::regSelT shown,
			input cpuPkg::wordT expected);
		emitInstr(cpuPkg::opMov4, regCx, x);
		emitInstr(cpuPkg::opMov4, regAx, y);
		emitInstr(op, selPair(regCx, regAx)); // unary ops work on ax
		showReg(shown, tag, expected);
	endtask

	task automatic logicOps();
		cpuPkg::wordT x, y, tag;
		logic cin;
		newProgram();
		for (int k = 0; k < 4; k++) begin
			x = randWord();
			y = randWord();
			if (k == 3) y = ~x; // disjoint bits so TEST gives zero
			cin = nextRandBit();
			tag = 16'h3000 + 16'(k);
			emitInstr(cpuPkg::opMov4, regBx, tag);
			emitInstr(cpuPkg::opScf, {15'd0, cin});
			logicCase(cpuPkg::opAnd, x, y, tag, regCx, x & y);
			logicCase(cpuPkg::opOr, x, y, tag, regCx, x | y);
			logicCase(cpuPkg::opXor, x, y, tag, regCx, x ^ y);
			logicCase(cpuPkg::opNot, x, y, tag, regAx, ~y);
			logicCase(cpuPkg::opNeg, x, y, tag, regAx, 16'd0 - y);
			logicCase(cpuPkg::opShl, x, y, tag, regAx, y << 1);
			logicCase(cpuPkg::opShr, x, y, tag, regAx, y >> 1);
			logicCase(cpuPkg::opTest, x, y, tag, regCx, x); // cx left alone
			showFlag(cpuPkg::opCzf, tag, (x & y) == 16'd0);
			showFlag(cpuPkg::opCff, tag, cin); // carry kept through all of them
		end
		runProgram("logic");
	endtask

	task automatic memoryAndStack();
		cpuPkg::wordT a, b, c, saved;
		a = randWord();
		b = randWord();
		c = randWord();
		newProgram();
		emitInstr(cpuPkg::opMov4, regAx, a);
		emitInstr(cpuPkg::opMov4, regCx, c);
		emitInstr(cpuPkg::opMov4, regBx, 16'h4001);
		emitInstr(cpuPkg::opMov5, 16'h0500, regAx);
		emitInstr(cpuPkg::opMov6, regDx, 16'h0500);
		emitInstr(cpuPkg::opOut);
		expectOut(16'h4001, a);
		emitInstr(cpuPkg::opCall, 16'h0200); // bp is 0x200 inside
		expectOut(16'h4001, a);
		emitInstr(cpuPkg::opMov2, regDx, 16'h0400); // bp back to 0 after RET
		emitInstr(cpuPkg::opOut);
		expectOut(16'h4001, c);
		emitInstr(cpuPkg::opMov4, regBx, b);
		emitInstr(cpuPkg::opPush, regAx);
		emitInstr(cpuPkg::opPush, regBx);
		emitInstr(cpuPkg::opPush, regCx);
		emitInstr(cpuPkg::opMov4, regAx, 16'd0);
		emitInstr(cpuPkg::opMov4, regBx, 16'd0);
		emitInstr(cpuPkg::opMov4, regCx, 16'd0);
		emitInstr(cpuPkg::opPop, regCx); // last in, first out
		emitInstr(cpuPkg::opPop, regBx);
		emitInstr(cpuPkg::opPop, regAx);
		showReg(regAx, b, a);
		showReg(regCx, b, c);
		saved = asmPc;
		asmPc = 16'h0200;
		emitInstr(cpuPkg::opMov1, 16'h0200, regCx); // lands at 0x400
		emitInstr(cpuPkg::opMov2, regDx, 16'h0300); // reads 0x500
		emitInstr(cpuPkg::opOut);
		emitInstr(cpuPkg::opRet);
		asmPc = saved;
		runProgram("memory and stack");
	endtask

	task automatic controlFlow();
		cpuPkg::wordT saved;
		newProgram();
		emitInstr(cpuPkg::opScf, 16'd1);
		jumpCase(cpuPkg::opJc, 1'b1, 16'h5001);
		jumpCase(cpuPkg::opJnc, 1'b0, 16'h5002);
		emitInstr(cpuPkg::opScf, 16'd0);
		jumpCase(cpuPkg::opJc, 1'b0, 16'h5003);
		jumpCase(cpuPkg::opJnc, 1'b1, 16'h5004);
		emitInstr(cpuPkg::opMov4, regDx, 16'h1234);
		emitInstr(cpuPkg::opMov4, regAx, 16'h1234);
		emitInstr(cpuPkg::opCmp); // zero and no overflow
		jumpCase(cpuPkg::opJz, 1'b1, 16'h5005);
		jumpCase(cpuPkg::opJnz, 1'b0, 16'h5006);
		jumpCase(cpuPkg::opJno, 1'b1, 16'h5007);
		jumpCase(cpuPkg::opJo, 1'b0, 16'h5008);
		emitInstr(cpuPkg::opMov4, regDx, 16'h8000);
		emitInstr(cpuPkg::opMov4, regAx, 16'h0001);
		emitInstr(cpuPkg::opCmp); // most negative minus one overflows
		jumpCase(cpuPkg::opJnz, 1'b1, 16'h5009);
		jumpCase(cpuPkg::opJz, 1'b0, 16'h500A);
		jumpCase(cpuPkg::opJo, 1'b1, 16'h500B);
		jumpCase(cpuPkg::opJno, 1'b0, 16'h500C);
		jumpCase(cpuPkg::opJmp, 1'b1, 16'h500D);
		emitInstr(cpuPkg::opCall, 16'h0200);
		expectOut(16'h5077, 16'h505B);
		emitInstr(cpuPkg::opMov4, regDx, 16'h50C0);
		emitInstr(cpuPkg::opOut);
		expectOut(16'h5077, 16'h50C0); // bx still set by the subroutine
		saved = asmPc;
		asmPc = 16'h0200;
		emitInstr(cpuPkg::opMov4, regBx, 16'h5077);
		emitInstr(cpuPkg::opMov4, regDx, 16'h505B);
		emitInstr(cpuPkg::opOut);
		emitInstr(cpuPkg::opRet);
		asmPc = saved;
		runProgram("control flow");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		lfsrState = 32'h0fc1_06da;
		eventCount = 0;
		valueErrors = 0;
		otherErrors = 0;
		registerMoves();
		arithmeticOps();
		logicOps();
		memoryAndStack();
		controlFlow();
		$display("OUT events %0d, value errors %0d, other errors %0d",
			eventCount, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+dv
src/cpuPkg.sv
src/progMemory.sv
src/callStack.sv
src/regFile.sv
src/alu.sv
src/cpuControl.sv
src/cpuTop.sv
dv/cpuTb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f all.f &&
./obj_dir/VcpuTb | tee /dev/stderr | grep -qx "TEST OK" &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }
